//--- build.f
+incdir+include
verilog/mem_sched_pkg.sv
verilog/bank_queue.sv
verilog/bank_scheduler.sv
verilog/data_path.sv
verilog/mem_sched_top.sv
test/tb_mem_sched.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mem_sched \
    -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"

[ -f sim.log ] && cat sim.log

grep -q "TEST PASSED" sim.log 2>/dev/null && exit 0 || exit 1

//--- test/tb_mem_sched.sv
`include "mem_sched_settings.svh"

module tb_mem_sched import mem_sched_pkg::*; ();

    localparam int          DEPTH          = `MS_QUEUE_DEPTH;
    localparam int          TABLE_LEN      = 200;
    localparam int          TIMEOUT_CYCLES = TABLE_LEN + 16 * DEPTH + 20;
    localparam logic [31:0] LFSR_SEED      = 32'h3b95;

    typedef struct packed {
        logic       push;
        bg_t        bg;
        ba_t        ba;
        mem_req_t   req;
        logic       stall;
        logic [2:0] test_id;
    } stim_row_t;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      req_push;
    bg_t       req_bg;
    ba_t       req_ba;
    mem_req_t  req;
    logic      req_full;
    logic      cmd_stall;
    logic      cmd_valid;
    mem_cmd_t  cmd;

    stim_row_t   stim_table [TABLE_LEN];
    int          fill_idx = 0;
    stim_row_t   applied;
    logic [31:0] lfsr_state = LFSR_SEED;

    // reference queues as seen between clock edges
    mem_req_t model_mem [16][DEPTH];
    int       model_cnt [16];
    int       model_rd  [16];
    int       m_grp_ptr;
    int       m_bank_ptr [4];
    logic     exp_valid;
    mem_cmd_t exp_cmd;

    int errors = 0;
    int checks = 0;
    int pushed = 0;
    int issued = 0;
    int cycle_cnt = 0;

    mem_sched_top u_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_push_i  (req_push),
        .req_bg_i    (req_bg),
        .req_ba_i    (req_ba),
        .req_i       (req),
        .req_full_o  (req_full),
        .cmd_stall_i (cmd_stall),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: queues not drained after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "pass_through";
            3'd1:    return "queue_order";
            3'd2:    return "stall_full";
            3'd3:    return "group_rr";
            3'd4:    return "bank_rr";
            3'd5:    return "random";
            default: return "drain";
        endcase
    endfunction

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic mem_req_t tagged_req(input int tag);
        mem_req_t r;
        r.t    = !tag[0];  // even tags write
        r.row  = row_t'(16'h1000 + tag);
        r.col  = col_t'(tag * 3 + 5);
        r.data = data_t'(16'hd000 ^ tag);
        r.idx  = idx_t'(tag);
        return r;
    endfunction

    task automatic add_row(input logic push, input bg_t bg, input ba_t ba,
                           input mem_req_t r, input logic stall, input logic [2:0] id);
        stim_table[fill_idx] = '{push: push, bg: bg, ba: ba, req: r, stall: stall, test_id: id};
        fill_idx++;
    endtask

    task automatic add_idle(input int n, input logic stall, input logic [2:0] id);
        for (int k = 0; k < n; k++) begin
            add_row(1'b0, 2'd0, 2'd0, '0, stall, id);
        end
    endtask

    task automatic build_table();
        logic [63:0] bits;
        stim_row_t   r;
        add_row(1'b1, 2'd2, 2'd1, tagged_req(0), 1'b0, 3'd0);
        add_idle(3, 1'b0, 3'd0);
        for (int k = 1; k <= 4; k++) begin
            add_row(1'b1, 2'd1, 2'd3, tagged_req(k), 1'b0, 3'd1);
        end
        add_idle(6, 1'b0, 3'd1);
        for (int k = 5; k <= 8; k++) begin
            add_row(1'b1, 2'd0, 2'd0, tagged_req(k), 1'b1, 3'd2);
        end
        add_row(1'b0, 2'd0, 2'd0, '0, 1'b1, 3'd2);  // addressed queue is full
        add_row(1'b0, 2'd3, 2'd2, '0, 1'b1, 3'd2);
        add_idle(6, 1'b0, 3'd2);
        add_row(1'b1, 2'd3, 2'd0, tagged_req(9), 1'b0, 3'd3);  // park group pointer on 3
        add_idle(3, 1'b0, 3'd3);
        for (int g = 0; g < 4; g++) begin
            add_row(1'b1, bg_t'(g), ba_t'(3 - g), tagged_req(10 + g), 1'b1, 3'd3);
        end
        add_idle(6, 1'b0, 3'd3);
        for (int g = 0; g < 4; g++) begin
            add_row(1'b1, bg_t'(g), ba_t'(g), tagged_req(14 + g), 1'b1, 3'd3);
        end
        add_idle(2, 1'b0, 3'd3);
        add_row(1'b1, 2'd0, 2'd2, tagged_req(18), 1'b1, 3'd3);
        add_row(1'b1, 2'd1, 2'd2, tagged_req(19), 1'b1, 3'd3);
        add_idle(7, 1'b0, 3'd3);
        add_row(1'b1, 2'd2, 2'd0, tagged_req(20), 1'b1, 3'd4);
        add_row(1'b1, 2'd2, 2'd2, tagged_req(21), 1'b1, 3'd4);
        add_row(1'b1, 2'd2, 2'd3, tagged_req(22), 1'b1, 3'd4);
        add_idle(5, 1'b0, 3'd4);
        while (fill_idx < TABLE_LEN) begin
            bits      = rand_bits(2);
            r.push    = (bits[1:0] != 2'b00);
            bits      = rand_bits(4);
            r.bg      = bits[3:2];
            r.ba      = bits[1:0];
            bits      = rand_bits(50);
            r.req     = bits[49:0];
            bits      = rand_bits(2);
            r.stall   = (bits[1:0] == 2'b00);
            r.test_id = 3'd5;
            stim_table[fill_idx] = r;
            fill_idx++;
        end
    endtask

    function automatic logic group_busy(input int g);
        return (model_cnt[g*4] + model_cnt[g*4+1] + model_cnt[g*4+2] + model_cnt[g*4+3]) != 0;
    endfunction

    // what the clock edge does with the inputs applied before it
    task automatic model_edge(input stim_row_t row);
        int g;
        int b;
        int q;
        g = -1;
        b = -1;
        exp_valid = 1'b0;
        if (!row.stall) begin
            for (int s = 1; s <= 4; s++) begin
                if (g < 0 && group_busy((m_grp_ptr + s) % 4)) begin
                    g = (m_grp_ptr + s) % 4;
                end
            end
        end
        if (g >= 0) begin
            for (int s = 1; s <= 4; s++) begin
                if (b < 0 && model_cnt[g*4 + (m_bank_ptr[g] + s) % 4] != 0) begin
                    b = (m_bank_ptr[g] + s) % 4;
                end
            end
            q             = g * 4 + b;
            exp_valid     = 1'b1;
            exp_cmd.req   = model_mem[q][model_rd[q]];
            exp_cmd.ba    = ba_t'(b);
            exp_cmd.bg    = bg_t'(g);
            model_rd[q]   = (model_rd[q] + 1) % DEPTH;
            model_cnt[q]  = model_cnt[q] - 1;
            m_grp_ptr     = g;
            m_bank_ptr[g] = b;
        end
        if (row.push) begin
            q = int'({row.bg, row.ba});
            model_mem[q][(model_rd[q] + model_cnt[q]) % DEPTH] = row.req;
            model_cnt[q] = model_cnt[q] + 1;
            pushed++;
        end
    endtask

    task automatic step_cycle(input stim_row_t row);
        stim_row_t r;
        int        q;
        logic      exp_full;
        model_edge(applied);
        checks++;
        assert (cmd_valid === exp_valid) else begin
            errors++;
            $display("[ERROR] %s: cmd_valid_o expected %0b actual %0b",
                     test_name(applied.test_id), exp_valid, cmd_valid);
        end
        if (cmd_valid === 1'b1) begin
            issued++;
        end
        if (exp_valid) begin
            checks++;
            assert (cmd === exp_cmd) else begin
                errors++;
                $display("[ERROR] %s: cmd_o expected %h actual %h",
                         test_name(applied.test_id), exp_cmd, cmd);
            end
        end
        r = row;
        q = int'({r.bg, r.ba});
        if (r.push && model_cnt[q] == DEPTH) begin
            r.push = 1'b0;
        end
        req_push  = r.push;
        req_bg    = r.bg;
        req_ba    = r.ba;
        req       = r.req;
        cmd_stall = r.stall;
        applied   = r;
        #1;
        exp_full = (model_cnt[q] == DEPTH);
        checks++;
        assert (req_full === exp_full) else begin
            errors++;
            $display("[ERROR] %s: req_full_o expected %0b actual %0b",
                     test_name(r.test_id), exp_full, req_full);
        end
    endtask

    function automatic int model_total();
        int sum;
        sum = 0;
        for (int q = 0; q < 16; q++) begin
            sum += model_cnt[q];
        end
        return sum;
    endfunction

    initial begin
        arst_n    = 1'b0;
        req_push  = 1'b0;
        req_bg    = '0;
        req_ba    = '0;
        req       = '0;
        cmd_stall = 1'b0;
        applied   = '0;
        exp_valid = 1'b0;
        exp_cmd   = '0;
        m_grp_ptr = 3;
        for (int q = 0; q < 16; q++) begin
            model_cnt[q] = 0;
            model_rd[q]  = 0;
        end
        for (int g = 0; g < 4; g++) begin
            m_bank_ptr[g] = 3;
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) begin
            @(negedge clk);
            step_cycle(stim_table[i]);
        end
        // idle until every queued request has left
        while (model_total() != 0 || exp_valid) begin
            @(negedge clk);
            step_cycle('{push: 1'b0, bg: 2'd0, ba: 2'd0, req: '0, stall: 1'b0, test_id: 3'd6});
        end
        checks++;
        assert (issued == pushed) else begin
            errors++;
            $display("[ERROR] drain: issued count expected %0d actual %0d", pushed, issued);
        end
        $display("errors: %0d of %0d checks, %0d pushed, %0d issued",
                 errors, checks, pushed, issued);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/mem_sched_top.sv
module mem_sched_top import mem_sched_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    // client request side
    input  logic     req_push_i,
    input  bg_t      req_bg_i,
    input  ba_t      req_ba_i,
    input  mem_req_t req_i,
    output logic     req_full_o,   // full flag of the addressed queue

    // command side
    input  logic     cmd_stall_i,
    output logic     cmd_valid_o,
    output mem_cmd_t cmd_o
);

    logic [15:0] push_vec;
    logic [15:0] pop_vec;
    logic [15:0] empty_vec;
    logic [15:0] full_vec;
    mem_req_t    heads [16];
    logic [3:0]  push_idx;
    logic [3:0]  pop_idx;
    logic [7:0]  bank_sel;
    bg_t         group_sel;
    ba_t         grant_ba;
    logic        issue;
    mem_cmd_t    cmd_d;

    // queue number is group*4 + bank
    assign push_idx   = {req_bg_i, req_ba_i};
    assign push_vec   = req_push_i ? (16'd1 << push_idx) : '0;
    assign req_full_o = full_vec[push_idx];

    // pop exactly the queue the scheduler granted
    assign grant_ba = bank_sel[{group_sel, 1'b0} +: 2];
    assign pop_idx  = {group_sel, grant_ba};
    assign pop_vec  = issue ? (16'd1 << pop_idx) : '0;

    for (genvar q = 0; q < 16; q++) begin : g_queue
        bank_queue u_queue (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .push_i   (push_vec[q]),
            .pop_i    (pop_vec[q]),
            .req_i    (req_i),
            .head_o   (heads[q]),
            .empty_o  (empty_vec[q]),
            .full_o   (full_vec[q])
        );
    end

    bank_scheduler u_sched (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .stall_i     (cmd_stall_i),
        .pending_i   (~empty_vec),
        .bank_sel_o  (bank_sel),
        .group_sel_o (group_sel),
        .issue_o     (issue)
    );

    data_path u_data_path (
        .heads_i     (heads),
        .bank_sel_i  (bank_sel),
        .group_sel_i (group_sel),
        .cmd_o       (cmd_d)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= issue;
        end
    end

    // payload only loads on issue, holds otherwise
    always_ff @(posedge clk_i) begin
        if (issue) begin
            cmd_o <= cmd_d;
        end
    end

    // a command on the output means the stall was low one cycle earlier
    a_valid_after_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cmd_valid_o |-> $past(!cmd_stall_i))
        else $error("mem_sched_top: command issued out of a stall cycle");

endmodule

//--- verilog/data_path.sv
module data_path import mem_sched_pkg::*; (
    input  mem_req_t   heads_i [16],  // group*4 + bank
    input  logic [7:0] bank_sel_i,
    input  bg_t        group_sel_i,
    output mem_cmd_t   cmd_o
);

    mem_req_t grp_req [4];  // winning head of each group
    ba_t      grp_ba  [4];
    ba_t      sel;

    // first level, bank select inside every group
    always_comb begin
        sel = '0;
        for (int g = 0; g < 4; g++) begin
            sel = bank_sel_i[g*2 +: 2];
            case (sel)
                2'd0: begin
                    grp_req[g] = heads_i[g*4 + 0];
                    grp_ba[g]  = 2'd0;
                end
                2'd1: begin
                    grp_req[g] = heads_i[g*4 + 1];
                    grp_ba[g]  = 2'd1;
                end
                2'd2: begin
                    grp_req[g] = heads_i[g*4 + 2];
                    grp_ba[g]  = 2'd2;
                end
                default: begin
                    grp_req[g] = heads_i[g*4 + 3];
                    grp_ba[g]  = 2'd3;
                end
            endcase
        end
    end

    // second level picks the group and tags the bank group
    always_comb begin
        case (group_sel_i)
            2'd0: begin
                cmd_o.req = grp_req[0];
                cmd_o.ba  = grp_ba[0];
                cmd_o.bg  = 2'd0;
            end
            2'd1: begin
                cmd_o.req = grp_req[1];
                cmd_o.ba  = grp_ba[1];
                cmd_o.bg  = 2'd1;
            end
            2'd2: begin
                cmd_o.req = grp_req[2];
                cmd_o.ba  = grp_ba[2];
                cmd_o.bg  = 2'd2;
            end
            default: begin
                cmd_o.req = grp_req[3];
                cmd_o.ba  = grp_ba[3];
                cmd_o.bg  = 2'd3;
            end
        endcase
    end

endmodule

//--- verilog/bank_scheduler.sv
module bank_scheduler import mem_sched_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        stall_i,
    input  logic [15:0] pending_i,   // one flag per queue, group*4 + bank
    output logic [7:0]  bank_sel_o,  // two bits per group
    output bg_t         group_sel_o,
    output logic        issue_o
);

    bg_t        grp_ptr_q;
    ba_t        bank_ptr_q [4];
    logic [3:0] grp_pending;
    ba_t        granted_ba;

    // first set bit after ptr, counting up and wrapping
    // returns ptr itself when nothing else is set
    function automatic logic [1:0] rr_pick(input logic [3:0] req, input logic [1:0] ptr);
        logic [1:0] idx;
        logic [1:0] pick;
        logic       found;
        pick  = ptr;
        found = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            idx = ptr + 2'(k);
            if (req[idx] && !found) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // every group gets a bank pick since data_path muxes banks before groups
    always_comb begin
        for (int g = 0; g < 4; g++) begin
            grp_pending[g]       = |pending_i[g*4 +: 4];
            bank_sel_o[g*2 +: 2] = rr_pick(pending_i[g*4 +: 4], bank_ptr_q[g]);
        end
    end

    assign group_sel_o = rr_pick(grp_pending, grp_ptr_q);
    assign granted_ba  = bank_sel_o[{group_sel_o, 1'b0} +: 2];
    assign issue_o     = |grp_pending && !stall_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grp_ptr_q <= 2'd3;  // first search starts at 0
            for (int g = 0; g < 4; g++) begin
                bank_ptr_q[g] <= 2'd3;
            end
        end else if (issue_o) begin
            grp_ptr_q               <= group_sel_o;
            bank_ptr_q[group_sel_o] <= granted_ba;
        end
    end

    // the pop in the top must never hit an empty queue
    a_grant_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_o |-> pending_i[{group_sel_o, granted_ba}])
        else $error("bank_scheduler: grant to a queue with nothing pending");

endmodule

//--- verilog/bank_queue.sv
`include "mem_sched_settings.svh"

module bank_queue import mem_sched_pkg::*; #(
    parameter int DEPTH = `MS_QUEUE_DEPTH
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     push_i,
    input  logic     pop_i,
    input  mem_req_t req_i,
    output mem_req_t head_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    mem_req_t mem_q [DEPTH];
    ptr_t     wr_ptr_q;
    ptr_t     rd_ptr_q;
    cnt_t     count_q;
    logic     do_push;
    logic     do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == cnt_t'(DEPTH));
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop); // a pop frees the slot in time
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // the client must watch req_full_o before pushing
    a_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i && full_o |-> pop_i)
        else $error("bank_queue: push into a full queue");

    // scheduler only pops queues it saw as pending
    a_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o)
        else $error("bank_queue: pop from an empty queue");

endmodule

//--- verilog/mem_sched_pkg.sv
`include "mem_sched_settings.svh"

package mem_sched_pkg;

    // request fields
    typedef logic [`MS_INDEX_BITS-1:0] idx_t;
    typedef logic [`MS_RA_BITS-1:0]    row_t;
    typedef logic [`MS_CA_BITS-1:0]    col_t;
    typedef logic [`MS_DATA_BITS-1:0]  data_t;

    // four banks per group, four groups
    typedef logic [1:0] ba_t;
    typedef logic [1:0] bg_t;

    // one queued request
    typedef struct packed {
        logic  t;    // 1 write, 0 read
        row_t  row;
        col_t  col;
        data_t data;
        idx_t  idx;
    } mem_req_t;

    // request plus the address of the queue it left
    typedef struct packed {
        mem_req_t req;
        ba_t      ba;
        bg_t      bg;
    } mem_cmd_t;

endpackage

//--- include/mem_sched_settings.svh
`ifndef MEM_SCHED_SETTINGS_SVH
`define MEM_SCHED_SETTINGS_SVH

// request field widths

// client tag carried through to the issued command
`define MS_INDEX_BITS 7

// row address
`define MS_RA_BITS 16

// column address
`define MS_CA_BITS 10

// write data, don't care on reads
`define MS_DATA_BITS 16

// queue sizing

// entries per bank queue, power of two and at least 2
`define MS_QUEUE_DEPTH 4

`endif
